/* thread_pkg.sv */
package thread_pkg;

  // table depth and derived widths
  localparam int MAX_THREADS = 8;
  // index into the thread table
  localparam int IDX_W = 3;
  // count needs one more bit to hold MAX_THREADS itself
  localparam int CNT_W = 4;

  // descriptor field widths
  localparam int ADDR_W = 16;
  localparam int CTX_W = 32;

  // one thread descriptor, context in the upper bits, address in the lower
  // both fields take part in a match
  typedef struct packed {
    logic [CTX_W-1:0]  ctx;
    logic [ADDR_W-1:0] addr;
  } thread_desc_t;

  // command channel opcodes
  typedef enum logic {
    OP_RUN  = 1'b0,
    OP_STOP = 1'b1
  } thread_op_e;

  // scheduler job FSM
  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    // stop: walking the table for a match
    S_SEARCH = 2'd1,
    // stop: last entry into the freed slot
    S_REMOVE = 2'd2,
    // next: done cycle of a next-thread job
    S_NEXT   = 2'd3
  } sched_state_e;

endpackage

/* sched_if.sv */
// command job between intake and scheduler
interface sched_cmd_if import thread_pkg::*; ();
  // held high from job start until done
  logic         start;
  thread_op_e   op;
  thread_desc_t desc;
  // single-cycle completion pulse
  logic         done;
  // result, valid with done
  logic         ok;

  modport master (output start, op, desc, input done, ok);
  modport slave (input start, op, desc, output done, ok);
endinterface

// next-thread job between output port and scheduler
interface sched_next_if import thread_pkg::*; ();
  logic         start;
  logic         done;
  // returned descriptor, valid with done
  thread_desc_t desc;
  // table was empty, desc is stale then
  logic         empty;

  modport master (output start, input done, desc, empty);
  modport slave (input start, output done, desc, empty);
endinterface

/* cmd_intake.sv */
module cmd_intake import thread_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  input  thread_op_e        op_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [CTX_W-1:0]  ctx_i,
  output logic              ack_o,
  output logic              ok_o,
  sched_cmd_if.master       job
);

  logic         start_q;
  thread_op_e   op_q;
  thread_desc_t desc_q;
  logic         take;

  // new request only once the previous ack has fallen
  assign take = req_i && !start_q && !ack_o;

  // handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
      ack_o   <= 1'b0;
      ok_o    <= 1'b0;
    end else begin
      if (job.done) begin
        // job finished, close the job and open phase 2
        start_q <= 1'b0;
        ack_o   <= 1'b1;
        ok_o    <= job.ok;
      end else if (ack_o && !req_i) begin
        // phase 4
        ack_o <= 1'b0;
      end else if (take) begin
        start_q <= 1'b1;
      end
    end
  end

  // request fields, captured with the first high req
  always_ff @(posedge clk) begin
    if (take) begin
      op_q        <= op_i;
      desc_q.addr <= addr_i;
      desc_q.ctx  <= ctx_i;
    end
  end

  assign job.start = start_q;
  assign job.op    = op_q;
  assign job.desc  = desc_q;

  // ack only ever answers a pending req
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(ack_o) |-> $past(req_i)
  );

endmodule

/* thread_scheduler.sv */
module thread_scheduler import thread_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  sched_cmd_if.slave cmd,
  sched_next_if.slave nxt
);

  thread_desc_t             tbl_q [MAX_THREADS];
  logic [CNT_W-1:0]         count_q;
  logic [IDX_W-1:0]         cursor_q;
  logic [IDX_W-1:0]         scan_idx_q;
  sched_state_e             state_q;

  logic                     cmd_done_q;
  logic                     cmd_ok_q;
  thread_desc_t             nxt_desc_q;
  logic                     nxt_empty_q;

  logic                     full;
  logic                     cmd_go;
  logic                     nxt_go;
  logic                     run_go;
  logic [CNT_W-1:0]         count_dec;
  logic [IDX_W-1:0]         last_idx;
  logic                     scan_last;
  logic [CNT_W-1:0]         cursor_inc;
  logic [IDX_W-1:0]         cursor_wrap;

  logic                     tbl_we;
  logic [IDX_W-1:0]         tbl_widx;
  thread_desc_t             tbl_wdata;

  assign full      = (count_q == CNT_W'(MAX_THREADS));
  // cmd_done_q still high means start has not dropped yet
  assign cmd_go    = (state_q == S_IDLE) && cmd.start && !cmd_done_q;
  // command wins a tie
  assign nxt_go    = (state_q == S_IDLE) && nxt.start && !cmd_go;
  assign run_go    = cmd_go && (cmd.op == OP_RUN) && !full;

  assign count_dec = count_q - 1'b1;
  assign last_idx  = count_dec[IDX_W-1:0];
  assign scan_last = ({1'b0, scan_idx_q} == count_dec);

  // round-robin step, wraps at the live count
  assign cursor_inc  = {1'b0, cursor_q} + 1'b1;
  assign cursor_wrap = (cursor_inc >= count_q) ? '0 : cursor_inc[IDX_W-1:0];

  // table write port, append on run or backfill on remove
  always_comb begin
    tbl_we    = 1'b0;
    tbl_widx  = count_q[IDX_W-1:0];
    tbl_wdata = cmd.desc;
    if (run_go) begin
      tbl_we = 1'b1;
    end else if (state_q == S_REMOVE) begin
      tbl_we    = 1'b1;
      tbl_widx  = scan_idx_q;
      tbl_wdata = tbl_q[last_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (tbl_we) begin
      tbl_q[tbl_widx] <= tbl_wdata;
    end
  end

  // job FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      count_q    <= '0;
      cursor_q   <= '0;
      scan_idx_q <= '0;
      cmd_done_q <= 1'b0;
      cmd_ok_q   <= 1'b0;
    end else begin
      // done is a one-cycle pulse
      cmd_done_q <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          if (cmd_go) begin
            if (cmd.op == OP_RUN) begin
              cmd_done_q <= 1'b1;
              cmd_ok_q   <= !full;
              if (!full) begin
                count_q <= count_q + 1'b1;
              end
            end else if (count_q == '0) begin
              // nothing to stop
              cmd_done_q <= 1'b1;
              cmd_ok_q   <= 1'b0;
            end else begin
              scan_idx_q <= '0;
              state_q    <= S_SEARCH;
            end
          end else if (nxt_go) begin
            state_q <= S_NEXT;
            if (count_q != '0) begin
              cursor_q <= cursor_wrap;
            end
          end
        end
        S_SEARCH: begin
          // one entry per cycle, first match wins
          if (tbl_q[scan_idx_q] == cmd.desc) begin
            state_q <= S_REMOVE;
          end else if (scan_last) begin
            cmd_done_q <= 1'b1;
            cmd_ok_q   <= 1'b0;
            state_q    <= S_IDLE;
          end else begin
            scan_idx_q <= scan_idx_q + 1'b1;
          end
        end
        S_REMOVE: begin
          count_q    <= count_dec;
          cmd_done_q <= 1'b1;
          cmd_ok_q   <= 1'b1;
          state_q    <= S_IDLE;
          // cursor past the shrunk table restarts at the front
          if ({1'b0, cursor_q} >= count_dec) begin
            cursor_q <= '0;
          end
        end
        S_NEXT: begin
          state_q <= S_IDLE;
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // next-thread result, taken at the current cursor before it moves
  always_ff @(posedge clk) begin
    if (nxt_go) begin
      nxt_empty_q <= (count_q == '0);
      nxt_desc_q  <= tbl_q[cursor_q];
    end
  end

  assign cmd.done  = cmd_done_q;
  assign cmd.ok    = cmd_ok_q;
  assign nxt.done  = (state_q == S_NEXT);
  assign nxt.desc  = nxt_desc_q;
  assign nxt.empty = nxt_empty_q;

  a_count_max: assert property (
    @(posedge clk) disable iff (rst)
    count_q <= CNT_W'(MAX_THREADS)
  );

  // masters hold start through the done cycle
  a_cmd_start_held: assert property (
    @(posedge clk) disable iff (rst)
    $fell(cmd.start) |-> $past(cmd.done)
  );

  a_nxt_start_held: assert property (
    @(posedge clk) disable iff (rst)
    $fell(nxt.start) |-> $past(nxt.done)
  );

endmodule

/* next_port.sv */
module next_port import thread_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_i,
  output logic              ack_o,
  output logic [ADDR_W-1:0] addr_o,
  output logic [CTX_W-1:0]  ctx_o,
  output logic              empty_o,
  sched_next_if.master      job
);

  logic start_q;
  logic take;

  // wait for ack low before a new request
  assign take = req_i && !start_q && !ack_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q <= 1'b0;
      ack_o   <= 1'b0;
      // no thread known yet
      empty_o <= 1'b1;
    end else begin
      if (job.done) begin
        start_q <= 1'b0;
        ack_o   <= 1'b1;
        empty_o <= job.empty;
      end else if (ack_o && !req_i) begin
        ack_o <= 1'b0;
      end else if (take) begin
        start_q <= 1'b1;
      end
    end
  end

  // returned descriptor, held until the next job completes
  always_ff @(posedge clk) begin
    if (job.done) begin
      addr_o <= job.desc.addr;
      ctx_o  <= job.desc.ctx;
    end
  end

  assign job.start = start_q;

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(ack_o) |-> $past(req_i)
  );

endmodule

/* thread_manager.sv */
module thread_manager import thread_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // command channel
  input  logic              cmd_req_i,
  input  thread_op_e        cmd_op_i,
  input  logic [ADDR_W-1:0] cmd_addr_i,
  input  logic [CTX_W-1:0]  cmd_ctx_i,
  output logic              cmd_ack_o,
  output logic              cmd_ok_o,
  // next-thread channel
  input  logic              nxt_req_i,
  output logic              nxt_ack_o,
  output logic [ADDR_W-1:0] nxt_addr_o,
  output logic [CTX_W-1:0]  nxt_ctx_o,
  output logic              nxt_empty_o
);

  sched_cmd_if  cmd_bus ();
  sched_next_if nxt_bus ();

  // run and stop requests
  cmd_intake u_cmd_intake (
    .clk    (clk),
    .rst    (rst),
    .req_i  (cmd_req_i),
    .op_i   (cmd_op_i),
    .addr_i (cmd_addr_i),
    .ctx_i  (cmd_ctx_i),
    .ack_o  (cmd_ack_o),
    .ok_o   (cmd_ok_o),
    .job    (cmd_bus.master)
  );

  // table, cursor and job FSM
  thread_scheduler u_thread_scheduler (
    .clk (clk),
    .rst (rst),
    .cmd (cmd_bus.slave),
    .nxt (nxt_bus.slave)
  );

  // round-robin output
  next_port u_next_port (
    .clk     (clk),
    .rst     (rst),
    .req_i   (nxt_req_i),
    .ack_o   (nxt_ack_o),
    .addr_o  (nxt_addr_o),
    .ctx_o   (nxt_ctx_o),
    .empty_o (nxt_empty_o),
    .job     (nxt_bus.master)
  );

endmodule

/* tb_thread_manager.sv */
module tb_thread_manager import thread_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  // watchdog budget per case in cycles
  localparam int WD_CYCLES = 40;
  // longest wait for a single ack edge
  localparam int ACK_WAIT = 30;

  logic              clk;
  logic              rst;
  logic              cmd_req;
  thread_op_e        cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [CTX_W-1:0]  cmd_ctx;
  logic              cmd_ack;
  logic              cmd_ok;
  logic              nxt_req;
  logic              nxt_ack;
  logic [ADDR_W-1:0] nxt_addr;
  logic [CTX_W-1:0]  nxt_ctx;
  logic              nxt_empty;

  // cases as read from the data file
  string             names[$];
  string             kinds[$];
  logic [ADDR_W-1:0] addrs[$];
  logic [CTX_W-1:0]  ctxs[$];
  logic              flags[$];
  logic [ADDR_W-1:0] exp_addrs[$];
  logic [CTX_W-1:0]  exp_ctxs[$];

  // results sampled while ack is high
  logic              got_ok;
  logic              got_empty;
  logic [ADDR_W-1:0] got_addr;
  logic [CTX_W-1:0]  got_ctx;

  int n_cases = 0;
  bit loaded = 1'b0;
  bit case_bad;
  int pass_cnt = 0;
  int fail_cnt = 0;

  thread_manager dut0 (
    .clk         (clk),
    .rst         (rst),
    .cmd_req_i   (cmd_req),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_ctx_i   (cmd_ctx),
    .cmd_ack_o   (cmd_ack),
    .cmd_ok_o    (cmd_ok),
    .nxt_req_i   (nxt_req),
    .nxt_ack_o   (nxt_ack),
    .nxt_addr_o  (nxt_addr),
    .nxt_ctx_o   (nxt_ctx),
    .nxt_empty_o (nxt_empty)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input string what,
                       input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %0h, actual %0h", name, what, exp, act);
      case_bad = 1'b1;
    end
  endtask

  // one full four-phase cycle on the command or the next-thread channel
  task automatic handshake(input bit on_nxt, input thread_op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [CTX_W-1:0] ctx,
                           input string name);
    int waited;
    bit seen;
    @(posedge clk);
    if (on_nxt) begin
      nxt_req <= 1'b1;
    end else begin
      cmd_op   <= op;
      cmd_addr <= addr;
      cmd_ctx  <= ctx;
      cmd_req  <= 1'b1;
    end
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < ACK_WAIT) begin
      @(posedge clk);
      waited++;
      seen = on_nxt ? (nxt_ack === 1'b1) : (cmd_ack === 1'b1);
    end
    if (!seen) begin
      $display("%s: no ack within %0d cycles of the request", name, ACK_WAIT);
      case_bad = 1'b1;
    end
    got_ok    = cmd_ok;
    got_empty = nxt_empty;
    got_addr  = nxt_addr;
    got_ctx   = nxt_ctx;
    // phase 3 then wait for ack to fall
    if (on_nxt) begin
      nxt_req <= 1'b0;
    end else begin
      cmd_req <= 1'b0;
    end
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < ACK_WAIT) begin
      @(posedge clk);
      waited++;
      seen = on_nxt ? (nxt_ack === 1'b0) : (cmd_ack === 1'b0);
    end
    if (!seen) begin
      $display("%s: ack stayed high after the request was dropped", name);
      case_bad = 1'b1;
    end
  endtask

  initial begin
    int fd;
    int n;
    string line;
    string nm;
    string kd;
    logic [ADDR_W-1:0] a;
    logic [CTX_W-1:0] c;
    logic f;
    logic [ADDR_W-1:0] ea;
    logic [CTX_W-1:0] ec;
    rst      <= 1'b1;
    cmd_req  <= 1'b0;
    cmd_op   <= OP_RUN;
    cmd_addr <= '0;
    cmd_ctx  <= '0;
    nxt_req  <= 1'b0;
    fd = $fopen("thread_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open thread_cases.txt, no cases to run");
    end else begin
      // comment and blank lines do not scan to seven fields
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%s %s %h %h %h %h %h", nm, kd, a, c, f, ea, ec);
        if (n == 7) begin
          names.push_back(nm);
          kinds.push_back(kd);
          addrs.push_back(a);
          ctxs.push_back(c);
          flags.push_back(f);
          exp_addrs.push_back(ea);
          exp_ctxs.push_back(ec);
        end
      end
      $fclose(fd);
    end
    n_cases = names.size();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < n_cases; i++) begin
      case_bad = 1'b0;
      if (kinds[i] == "NEXT") begin
        handshake(1'b1, OP_RUN, '0, '0, names[i]);
        check(names[i], "empty", flags[i], got_empty);
        // descriptor only means something on a non-empty table
        if (flags[i] == 1'b0) begin
          check(names[i], "addr", exp_addrs[i], got_addr);
          check(names[i], "ctx", exp_ctxs[i], got_ctx);
        end
      end else if (kinds[i] == "RUN" || kinds[i] == "STOP") begin
        handshake(1'b0, (kinds[i] == "STOP") ? OP_STOP : OP_RUN, addrs[i], ctxs[i],
                  names[i]);
        check(names[i], "ok", flags[i], got_ok);
      end else begin
        $display("%s: unknown request kind %s", names[i], kinds[i]);
        case_bad = 1'b1;
      end
      if (case_bad) begin
        fail_cnt++;
        $display("%-14s failed", names[i]);
      end else begin
        pass_cnt++;
        $display("%-14s passed", names[i]);
      end
    end
    $display("cases passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && n_cases > 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // run length scales with the number of cases, one spare case of slack
  initial begin
    wait (loaded);
    #(((n_cases + 1) * WD_CYCLES + RESET_CYCLES) * PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* thread_cases.txt */
# name kind addr ctx flag exp_addr exp_ctx, all numbers in hex
# flag is the expected ok for RUN and STOP, the expected empty for NEXT
next_empty NEXT 0 0 1 0 0
stop_empty STOP 1000 c0000000 0 0 0
run_t0 RUN 1000 c0000000 1 0 0
run_t1 RUN 1100 c0000001 1 0 0
run_t2 RUN 1200 c0000002 1 0 0
run_t3 RUN 1300 c0000003 1 0 0
run_t4 RUN 1400 c0000004 1 0 0
run_t5 RUN 1500 c0000005 1 0 0
run_t6 RUN 1600 c0000006 1 0 0
run_t7 RUN 1700 c0000007 1 0 0
run_full RUN 1800 c0000008 0 0 0
rr_0 NEXT 0 0 0 1000 c0000000
rr_1 NEXT 0 0 0 1100 c0000001
rr_2 NEXT 0 0 0 1200 c0000002
rr_3 NEXT 0 0 0 1300 c0000003
rr_4 NEXT 0 0 0 1400 c0000004
rr_5 NEXT 0 0 0 1500 c0000005
rr_6 NEXT 0 0 0 1600 c0000006
rr_7 NEXT 0 0 0 1700 c0000007
rr_wrap NEXT 0 0 0 1000 c0000000
stop_ctx_diff STOP 1300 deadbeef 0 0 0
stop_absent STOP 2000 c0000000 0 0 0
stop_t2 STOP 1200 c0000002 1 0 0
next_t1 NEXT 0 0 0 1100 c0000001
next_t7 NEXT 0 0 0 1700 c0000007
stop_t6 STOP 1600 c0000006 1 0 0
next_t3 NEXT 0 0 0 1300 c0000003
next_t4 NEXT 0 0 0 1400 c0000004
stop_t0 STOP 1000 c0000000 1 0 0
next_t5 NEXT 0 0 0 1500 c0000005
stop_t5 STOP 1500 c0000005 1 0 0
stop_t1 STOP 1100 c0000001 1 0 0
stop_t7 STOP 1700 c0000007 1 0 0
stop_t3 STOP 1300 c0000003 1 0 0
stop_t4 STOP 1400 c0000004 1 0 0
next_drained NEXT 0 0 1 0 0

/* flist.f */
thread_pkg.sv
sched_if.sv
cmd_intake.sv
thread_scheduler.sv
next_port.sv
thread_manager.sv
tb_thread_manager.sv
